// File: source/ttl_timer_pkg.sv
package ttl_timer_pkg;

    // width of reload, count and APB data
    localparam int data_width = 8;

    // register offsets on paddr
    localparam logic [1:0] addr_reload  = 2'd0;
    localparam logic [1:0] addr_control = 2'd1;
    localparam logic [1:0] addr_count   = 2'd2;
    localparam logic [1:0] addr_status  = 2'd3;

    // control word layout, bit 0 first from the right
    typedef struct packed {
        logic [4:0] reserved;
        // write one to clear the flag, never stored
        logic       irq_clear;
        logic       irq_en;
        logic       run;
    } timer_ctrl_t;

    // one data word, read as a reload value or as control bits
    // depending on which offset it goes to
    typedef union packed {
        logic [data_width-1:0] reload;
        timer_ctrl_t           ctrl;
    } timer_word_u;

endpackage

// File: source/ttl_parts.sv
`timescale 1ns/1ps

// presettable 4-bit binary counter, async clear
module jt74161 (
    input  logic       cet,
    input  logic       cep,
    input  logic       ld_b,
    input  logic       clk,
    input  logic       cl_b,
    input  logic [3:0] d,
    output logic [3:0] q,
    output logic       ca
);

    // ripple carry only counts cet, not cep
    assign ca = &{q, cet};

    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            q <= 4'd0;
        end else if (!ld_b) begin
            q <= d;
        end else if (cep && cet) begin
            q <= q + 4'd1;
        end
    end

endmodule

// 3-to-8 decoder, active low outputs
module jt74138 (
    input  logic       e1_b,
    input  logic       e2_b,
    input  logic       e3,
    input  logic [2:0] a,
    output logic [7:0] y_b
);

    always_comb begin
        if (e1_b || e2_b || !e3) begin
            y_b = 8'hff;
        end else begin
            y_b = ~(8'd1 << a);
        end
    end

endmodule

// quad 2-input mux with strobe
module jt74157 (
    input  logic       sel,
    input  logic       st_l,
    input  logic [3:0] A,
    input  logic [3:0] B,
    output logic [3:0] Y
);

    always_comb begin
        // strobe high forces all outputs low
        if (st_l) begin
            Y = 4'd0;
        end else if (sel) begin
            Y = B;
        end else begin
            Y = A;
        end
    end

endmodule

// octal D flip-flop with clear
module jt74273 (
    input  logic [7:0] d,
    input  logic       clk,
    input  logic       cl_b,
    output logic [7:0] q
);

    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            q <= 8'd0;
        end else begin
            q <= d;
        end
    end

endmodule

// File: source/timer_ctrl_if.sv
`timescale 1ns/1ps

interface timer_ctrl_if import ttl_timer_pkg::*; ();

    logic                  run;
    // one cycle after a reload write
    logic                  restart;
    logic [data_width-1:0] reload;
    logic [data_width-1:0] count;
    // count at 255 while running
    logic                  tick;

    // register block side
    modport regs (
        output run,
        output restart,
        output reload,
        input  count,
        input  tick
    );

    // counter chain side
    modport chain (
        input  run,
        input  restart,
        input  reload,
        output count,
        output tick
    );

endinterface

// File: source/timer_regs.sv
`timescale 1ns/1ps

module timer_regs import ttl_timer_pkg::*; (
    input  logic                  clk,
    input  logic                  cl_b,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [1:0]            paddr,
    input  logic [data_width-1:0] pwdata,
    output logic [data_width-1:0] prdata,
    output logic                  irq,
    timer_ctrl_if.regs            ctrl
);

    logic                  wr_access;
    logic                  rd_access;
    logic [7:0]            wr_strobe_b;
    logic                  wr_reload;
    logic                  wr_control;
    timer_word_u           wdata;
    timer_word_u           ctrl_rd;
    logic [data_width-1:0] reload_d;
    logic [data_width-1:0] reload_q;
    logic                  irq_en;

    // access phase only, no wait states
    assign wr_access = psel & penable & pwrite;
    assign rd_access = psel & penable & ~pwrite;
    assign wdata     = pwdata;

    // offset decode, upper select line tied low
    jt74138 wr_decode (
        .e1_b (1'b0),
        .e2_b (1'b0),
        .e3   (wr_access),
        .a    ({1'b0, paddr}),
        .y_b  (wr_strobe_b)
    );

    assign wr_reload  = ~wr_strobe_b[addr_reload];
    assign wr_control = ~wr_strobe_b[addr_control];

    // recirculate held reload unless offset 0 is written
    jt74157 reload_mux_lo (
        .sel  (wr_reload),
        .st_l (1'b0),
        .A    (reload_q[3:0]),
        .B    (wdata.reload[3:0]),
        .Y    (reload_d[3:0])
    );

    jt74157 reload_mux_hi (
        .sel  (wr_reload),
        .st_l (1'b0),
        .A    (reload_q[data_width-1:4]),
        .B    (wdata.reload[data_width-1:4]),
        .Y    (reload_d[data_width-1:4])
    );

    jt74273 reload_reg (
        .d    (reload_d),
        .clk  (clk),
        .cl_b (cl_b),
        .q    (reload_q)
    );

    assign ctrl.reload = reload_q;

    // run, irq_en and the restart pulse
    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            ctrl.run     <= 1'b0;
            ctrl.restart <= 1'b0;
            irq_en       <= 1'b0;
        end else begin
            ctrl.restart <= wr_reload;
            if (wr_control) begin
                ctrl.run <= wdata.ctrl.run;
                irq_en   <= wdata.ctrl.irq_en;
            end
        end
    end

    // sticky flag, a tick beats a clear on the same edge
    always_ff @(posedge clk or negedge cl_b) begin
        if (!cl_b) begin
            irq <= 1'b0;
        end else if (ctrl.tick && irq_en) begin
            irq <= 1'b1;
        end else if (wr_control && wdata.ctrl.irq_clear) begin
            irq <= 1'b0;
        end
    end

    // readback of the control word, irq_clear reads as zero
    always_comb begin
        ctrl_rd             = '0;
        ctrl_rd.ctrl.run    = ctrl.run;
        ctrl_rd.ctrl.irq_en = irq_en;
    end

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                addr_reload:  prdata = reload_q;
                addr_control: prdata = ctrl_rd;
                addr_count:   prdata = ctrl.count;
                addr_status:  prdata = {{(data_width - 1){1'b0}}, irq};
                default:      prdata = '0;
            endcase
        end
    end

endmodule

// File: source/timer_chain.sv
`timescale 1ns/1ps

module timer_chain import ttl_timer_pkg::*; (
    input  logic        clk,
    input  logic        cl_b,
    timer_ctrl_if.chain ctrl
);

    logic [3:0] q_lo;
    logic [3:0] q_hi;
    logic       ca_lo;
    logic       ca_hi;
    logic       ld_b;

    // load on restart or when the whole chain wraps
    assign ld_b = ~(ctrl.restart | ca_hi);

    // low nibble, enabled by run on both count inputs
    jt74161 count_lo (
        .cet  (ctrl.run),
        .cep  (ctrl.run),
        .ld_b (ld_b),
        .clk  (clk),
        .cl_b (cl_b),
        .d    (ctrl.reload[3:0]),
        .q    (q_lo),
        .ca   (ca_lo)
    );

    // high nibble steps on the low carry
    jt74161 count_hi (
        .cet  (ca_lo),
        .cep  (ctrl.run),
        .ld_b (ld_b),
        .clk  (clk),
        .cl_b (cl_b),
        .d    (ctrl.reload[data_width-1:4]),
        .q    (q_hi),
        .ca   (ca_hi)
    );

    assign ctrl.count = {q_hi, q_lo};

    // carry out of the top stage is the tick
    assign ctrl.tick = ca_hi;

endmodule

// File: source/ttl_timer_top.sv
`timescale 1ns/1ps

module ttl_timer_top import ttl_timer_pkg::*; (
    input  logic                  clk,
    input  logic                  cl_b,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [1:0]            paddr,
    input  logic [data_width-1:0] pwdata,
    output logic [data_width-1:0] prdata,
    output logic                  irq
);

    // register block to counter chain
    timer_ctrl_if ctrl_if ();

    // APB slave, reload storage and interrupt flag
    timer_regs timer_regs_inst (
        .clk     (clk),
        .cl_b    (cl_b),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .irq     (irq),
        .ctrl    (ctrl_if.regs)
    );

    // two-stage counter
    timer_chain timer_chain_inst (
        .clk  (clk),
        .cl_b (cl_b),
        .ctrl (ctrl_if.chain)
    );

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

// free-running clock, 100 ns period
module tb_clock_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #50;
            clk = ~clk;
        end
    end

endmodule

// File: verification/ttl_timer_assertions.sv
`timescale 1ns/1ps

module ttl_timer_assertions import ttl_timer_pkg::*; (
    input logic                  clk,
    input logic                  cl_b,
    input logic                  run,
    input logic                  restart,
    input logic [data_width-1:0] reload,
    input logic [data_width-1:0] count,
    input logic                  irq,
    input logic                  ctrl_write
);

    // restart is a single-cycle pulse
    restart_one_cycle: assert property (
        @(posedge clk) disable iff (!cl_b) restart |=> !restart
    ) else $error("restart stayed high for more than one cycle");

    // stopped and not restarting, the count holds
    count_holds: assert property (
        @(posedge clk) disable iff (!cl_b) (!run && !restart) |=> $stable(count)
    ) else $error("count changed while run was low");

    // running, step by one or wrap back to reload
    count_steps: assert property (
        @(posedge clk) disable iff (!cl_b) (run && !restart) |=>
            (count == data_width'($past(count) + 1)) || (count == $past(reload))
    ) else $error("count neither incremented nor reloaded");

    // sticky flag only drops on a control write
    irq_sticky: assert property (
        @(posedge clk) disable iff (!cl_b) (irq && !ctrl_write) |=> irq
    ) else $error("irq fell without a control write");

endmodule

// count and restart reach the register block through the interface
bind timer_regs ttl_timer_assertions regs_checks (
    .clk(clk), .cl_b(cl_b), .run(ctrl.run), .restart(ctrl.restart),
    .reload(ctrl.reload), .count(ctrl.count), .irq(irq), .ctrl_write(wr_control)
);

// File: verification/ttl_timer_tb.sv
`timescale 1ns/1ps

module ttl_timer_tb import ttl_timer_pkg::*; ();

    typedef struct {
        logic [data_width-1:0] reload;
        int                    ticks;
        int                    period;
    } tick_entry_t;

    logic                  clk;
    logic                  cl_b;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [1:0]            paddr;
    logic [data_width-1:0] pwdata;
    logic [data_width-1:0] prdata;
    logic                  irq;
    tick_entry_t           tick_table[$];
    int                    cycle = 0;
    int                    timeout_limit = 0;
    int                    last_access = 0;
    int                    pass_count = 0;
    int                    fail_count = 0;
    int                    test_errors = 0;

    tb_clock_gen clock_gen (.clk(clk));

    ttl_timer_top ttl_timer_top_inst (.*);

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (timeout_limit > 0 && cycle >= timeout_limit) begin
            $display("timeout: run stopped after %0d cycles, a test never completed", cycle);
            $display("Checks failed");
            $finish;
        end
    end

    // setup then access phase, inputs move 5 ns after the edge
    task apb_transfer(input logic write, input logic [1:0] addr,
                      input logic [data_width-1:0] data, output logic [data_width-1:0] rdata);
        @(posedge clk);
        #5;
        psel = 1'b1;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #5;
        penable = 1'b1;
        #1;
        rdata = prdata;
        @(posedge clk);
        #5;
        // index of the edge that ended the access phase
        last_access = cycle;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task check_value(input string what, input logic signed [31:0] got,
                     input logic signed [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task write_reg(input logic [1:0] addr, input logic [data_width-1:0] data);
        logic [data_width-1:0] unused;
        apb_transfer(1'b1, addr, data, unused);
    endtask

    task read_check(input string what, input logic [1:0] addr, input int exp);
        logic [data_width-1:0] got;
        apb_transfer(1'b0, addr, '0, got);
        check_value(what, got, exp);
    endtask

    function automatic logic [data_width-1:0] ctrl_word(input logic run, input logic irq_en,
                                                        input logic irq_clear);
        timer_word_u w;
        w = '0;
        w.ctrl.run = run;
        w.ctrl.irq_en = irq_en;
        w.ctrl.irq_clear = irq_clear;
        return w;
    endfunction

    // returns the edge index where irq was first seen high
    task wait_irq_rise(input int limit, output int at_cycle);
        int waited;
        waited = 0;
        at_cycle = -1;
        while (at_cycle < 0 && waited < limit) begin
            @(posedge clk);
            #1;
            waited++;
            if (irq) at_cycle = cycle;
        end
        if (at_cycle < 0) begin
            $display("%0t: irq never rose within %0d cycles", $time, limit);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task hold_irq_low(input int cycles);
        logic rose;
        rose = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
            rose = rose | irq;
        end
        check_value("irq while it should stay low", rose, 0);
    endtask

    task end_test(input string name);
        if (test_errors == 0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        int rise_cycle;
        int prev_cycle;
        logic [data_width-1:0] first_count;
        tick_entry_t e;
        void'($urandom(56448));
        cl_b = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        // reload, ticks to observe, period of 256 minus reload
        tick_table.push_back('{8'd0, 2, 256});
        tick_table.push_back('{8'd100, 3, 156});
        tick_table.push_back('{8'd200, 3, 56});
        tick_table.push_back('{8'd240, 4, 16});
        tick_table.push_back('{8'd250, 4, 6});
        repeat (2) begin
            e.reload = 8'($urandom % 241);
            e.ticks = 3;
            e.period = 256 - int'(e.reload);
            tick_table.push_back(e);
        end
        foreach (tick_table[i]) timeout_limit += tick_table[i].period * tick_table[i].ticks;
        timeout_limit = 2 * timeout_limit + 2000;

        repeat (8) @(posedge clk);
        #5;
        cl_b = 1'b1;
        check_value("irq after reset", irq, 0);
        for (int a = 0; a < 4; a++) read_check("register after reset", 2'(a), 0);
        end_test("reset values");

        write_reg(addr_reload, 8'h5a);
        read_check("reload readback", addr_reload, 8'h5a);
        read_check("count after restart", addr_count, 8'h5a);
        write_reg(addr_control, ctrl_word(1'b0, 1'b1, 1'b1));
        read_check("control readback", addr_control, 8'h02);
        write_reg(addr_control, ctrl_word(1'b1, 1'b0, 1'b0));
        read_check("control readback", addr_control, 8'h01);
        end_test("register readback");

        foreach (tick_table[i]) begin
            e = tick_table[i];
            write_reg(addr_control, ctrl_word(1'b1, 1'b0, 1'b1));
            write_reg(addr_reload, e.reload);
            // chain loads on the edge after the access edge
            prev_cycle = last_access + 1;
            write_reg(addr_control, ctrl_word(1'b1, 1'b1, 1'b1));
            for (int k = 0; k < e.ticks; k++) begin
                wait_irq_rise(e.period + 4, rise_cycle);
                check_value($sformatf("interval for reload %0d", e.reload),
                            rise_cycle - prev_cycle, e.period);
                prev_cycle = rise_cycle;
                write_reg(addr_control, ctrl_word(1'b1, 1'b1, 1'b1));
            end
            end_test($sformatf("tick interval, reload %0d", e.reload));
        end

        write_reg(addr_control, ctrl_word(1'b1, 1'b0, 1'b1));
        repeat (20) @(posedge clk);
        write_reg(addr_control, ctrl_word(1'b0, 1'b1, 1'b1));
        apb_transfer(1'b0, addr_count, '0, first_count);
        hold_irq_low(20);
        read_check("held count", addr_count, first_count);
        end_test("hold");

        write_reg(addr_control, ctrl_word(1'b1, 1'b0, 1'b1));
        write_reg(addr_reload, 8'd200);
        hold_irq_low(3 * 56);
        write_reg(addr_control, ctrl_word(1'b1, 1'b1, 1'b0));
        wait_irq_rise(56 + 2, rise_cycle);
        end_test("interrupt gating");

        // stop without clearing, the flag has to survive reads
        write_reg(addr_control, ctrl_word(1'b0, 1'b1, 1'b0));
        read_check("status with flag set", addr_status, 1);
        repeat (10) @(posedge clk);
        read_check("status on second read", addr_status, 1);
        check_value("irq before clear", irq, 1);
        write_reg(addr_control, ctrl_word(1'b0, 1'b1, 1'b1));
        check_value("irq after clear", irq, 0);
        read_check("status after clear", addr_status, 0);
        end_test("sticky clear");

        $display("checks: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: project.f
source/ttl_timer_pkg.sv
source/ttl_parts.sv
source/timer_ctrl_if.sv
source/timer_regs.sv
source/timer_chain.sv
source/ttl_timer_top.sv
verification/tb_clock_gen.sv
verification/ttl_timer_assertions.sv
verification/ttl_timer_tb.sv
